//--- ar_burst_ctrl.sv
`timescale 1ns/10ps

module ar_burst_ctrl import ro_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  task_in_valid,
   input  logic [EO_W-1:0]       in_eo_begin,
   input  logic [EO_W-1:0]       in_eo_end,
   input  logic [ADDR_W-1:0]     neighbor_base,
   input  logic                  arready,
   input  logic                  thread_avail,
   input  logic                  tag_avail,
   input  logic [THREAD_W-1:0]   alloc_thread,
   output logic                  task_in_ready,
   output logic                  thread_pop,
   output logic                  tag_pop,
   output logic                  ctx_load,
   output logic [CNT_W-1:0]      ctx_count,
   output logic                  arvalid,
   output logic [ADDR_W-1:0]     araddr,
   output logic [ELEM_IDX_W-1:0] arlen,
   output logic [THREAD_W-1:0]   req_thread,
   output logic [ELEM_IDX_W-1:0] req_start,
   output logic [REQ_CNT_W-1:0]  req_count
);

   logic                 state;
   logic [ADDR_W-1:0]    cur_addr;
   logic [CNT_W-1:0]     left;        // elements not yet requested
   logic [THREAD_W-1:0]  cur_thread;
   logic                 empty_task;
   logic                 accept;
   logic                 ar_fire;
   logic [REQ_CNT_W-1:0] room;        // elements up to the line end
   logic [REQ_CNT_W-1:0] chunk;
   logic                 last_req;

   // empty ranges are swallowed even while a burst is in progress
   assign empty_task    = (in_eo_end == in_eo_begin);
   assign task_in_ready = task_in_valid &
                          (empty_task | ((state == ST_IDLE) & thread_avail));
   assign accept        = task_in_valid & task_in_ready & !empty_task;

   assign thread_pop = accept;
   assign ctx_load   = accept;
   assign ctx_count  = CNT_W'(in_eo_end - in_eo_begin);

   assign req_start = cur_addr[ELEM_OFF_W +: ELEM_IDX_W];
   assign room      = REQ_CNT_W'(ELEMS_PER_LINE) - REQ_CNT_W'(req_start);
   assign last_req  = (left <= CNT_W'(room));
   assign chunk     = last_req ? REQ_CNT_W'(left) : room;

   assign arvalid    = (state == ST_ISSUE) & tag_avail;   // no tag, no request
   assign araddr     = cur_addr;
   assign arlen      = ELEM_IDX_W'(chunk - 1'b1);
   assign ar_fire    = arvalid & arready;
   assign tag_pop    = ar_fire;
   assign req_thread = cur_thread;
   assign req_count  = chunk;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= ST_IDLE;
      end else begin
         case (state)
            ST_IDLE: begin
               if (accept) begin
                  state <= ST_ISSUE;
               end
            end
            ST_ISSUE: begin
               if (ar_fire && last_req) begin
                  state <= ST_IDLE;
               end
            end
            default: state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         cur_addr   <= neighbor_base + (ADDR_W'(in_eo_begin) << ELEM_OFF_W);
         left       <= ctx_count;
         cur_thread <= alloc_thread;
      end else if (ar_fire) begin
         cur_addr <= cur_addr + (ADDR_W'(chunk) << ELEM_OFF_W);   // next line start
         left     <= left - CNT_W'(chunk);
      end
   end

   a_ar_hold : assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arlen))
      else $error("read request changed before arready");

endmodule

//--- line_unpacker.sv
`timescale 1ns/10ps

module line_unpacker import ro_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  req_we,
   input  logic [TAG_W-1:0]      req_tag,
   input  logic [THREAD_W-1:0]   req_thread,
   input  logic [ELEM_IDX_W-1:0] req_start,
   input  logic [REQ_CNT_W-1:0]  req_count,
   input  logic                  rvalid,
   input  logic [TAG_W-1:0]      rid,
   input  logic [LINE_W-1:0]     rdata,
   input  logic                  out_ready,
   output logic                  rready,
   output logic                  tag_push,
   output logic [TAG_W-1:0]      tag_push_id,
   output logic                  out_valid,
   output logic [DATA_W-1:0]     out_data,
   output logic [THREAD_W-1:0]   out_thread
);

   // one entry per outstanding read tag
   logic [THREAD_W-1:0]       tab_thread [N_TAGS];
   logic [ELEM_IDX_W-1:0]     tab_start  [N_TAGS];
   logic [REQ_CNT_W-1:0]      tab_count  [N_TAGS];

   logic                      line_valid;
   logic [LINE_W-1:0]         line;
   logic [ELEMS_PER_LINE-1:0] mask;       // elements still to send
   logic [ELEMS_PER_LINE-1:0] new_mask;
   logic [ELEMS_PER_LINE-1:0] next_mask;
   logic [ELEM_IDX_W-1:0]     elem_idx;
   logic [REQ_CNT_W-1:0]      end_idx;
   logic                      r_fire;
   logic                      out_fire;

   always_ff @(posedge clk) begin
      if (req_we) begin
         tab_thread[req_tag] <= req_thread;
         tab_start[req_tag]  <= req_start;
         tab_count[req_tag]  <= req_count;
      end
   end

   assign rready      = !line_valid;
   assign r_fire      = rvalid & rready;
   assign tag_push    = r_fire;   // tag is free once its line is held here
   assign tag_push_id = rid;

   always_comb begin
      end_idx = REQ_CNT_W'(tab_start[rid]) + tab_count[rid];
      for (int k = 0; k < ELEMS_PER_LINE; k++) begin
         new_mask[k] = (REQ_CNT_W'(k) >= REQ_CNT_W'(tab_start[rid])) &&
                       (REQ_CNT_W'(k) < end_idx);
      end
   end

   // lowest pending element goes first
   always_comb begin
      elem_idx = '0;
      for (int k = ELEMS_PER_LINE - 1; k >= 0; k--) begin
         if (mask[k]) begin
            elem_idx = ELEM_IDX_W'(k);
         end
      end
      next_mask = mask;
      next_mask[elem_idx] = 1'b0;
   end

   assign out_valid = line_valid;
   assign out_data  = line[elem_idx*DATA_W +: DATA_W];
   assign out_fire  = out_valid & out_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         line_valid <= 1'b0;
         mask       <= '0;
      end else if (r_fire) begin
         line_valid <= 1'b1;
         mask       <= new_mask;
      end else if (out_fire) begin
         mask <= next_mask;
         if (next_mask == '0) begin
            line_valid <= 1'b0;   // line drained, take the next one
         end
      end
   end

   always_ff @(posedge clk) begin
      if (r_fire) begin
         line       <= rdata;
         out_thread <= tab_thread[rid];
      end
   end

   a_mask_live : assert property (@(posedge clk) disable iff (!rstn)
      out_valid |-> (mask != '0))
      else $error("line held with no pending element");

endmodule

//--- ro_pkg.sv
package ro_pkg;

   localparam int ADDR_W         = 32;   // byte address
   localparam int TS_W           = 32;
   localparam int VID_W          = 32;   // vertex id
   localparam int EO_W           = 32;   // edge offset
   localparam int DATA_W         = 64;   // one edge entry
   localparam int LINE_W         = 512;  // one read line
   localparam int ELEM_BYTES     = 8;
   localparam int ELEMS_PER_LINE = 8;
   localparam int ELEM_IDX_W     = 3;
   localparam int ELEM_OFF_W     = 3;    // byte offset bits inside an element

   // request length in elements, 1 to ELEMS_PER_LINE
   localparam int REQ_CNT_W      = ELEM_IDX_W + 1;

   localparam int TAG_W          = 3;
   localparam int N_TAGS         = 8;
   localparam int THREAD_W       = 2;
   localparam int N_THREADS      = 4;
   localparam int CNT_W          = 16;   // remaining edges per task

   // burst controller states
   localparam logic ST_IDLE      = 1'b0;
   localparam logic ST_ISSUE     = 1'b1;

endpackage

//--- ro_stage.f
ro_pkg.sv
tag_free_list.sv
ar_burst_ctrl.sv
line_unpacker.sv
thread_context.sv
ro_stage.sv
tb_ro_stage.sv

//--- ro_stage.sv
`timescale 1ns/10ps

module ro_stage import ro_pkg::*; (
   input  logic                  clk,
   input  logic                  rstn,

   input  logic                  task_in_valid,
   output logic                  task_in_ready,
   input  logic [TS_W-1:0]       in_ts,
   input  logic [VID_W-1:0]      in_locale,
   input  logic [EO_W-1:0]       in_eo_begin,
   input  logic [EO_W-1:0]       in_eo_end,

   input  logic [ADDR_W-1:0]     neighbor_base,

   output logic                  arvalid,
   input  logic                  arready,
   output logic [ADDR_W-1:0]     araddr,
   output logic [ELEM_IDX_W-1:0] arlen,
   output logic [TAG_W-1:0]      arid,

   input  logic                  rvalid,
   output logic                  rready,
   input  logic [TAG_W-1:0]      rid,
   input  logic [LINE_W-1:0]     rdata,

   output logic                  out_valid,
   input  logic                  out_ready,
   output logic [TS_W-1:0]       out_ts,
   output logic [VID_W-1:0]      out_locale,
   output logic [DATA_W-1:0]     out_data,
   output logic                  out_last,

   output logic                  idle
);

   logic                  thread_empty;
   logic                  thread_avail;
   logic                  thread_pop;
   logic [THREAD_W-1:0]   alloc_thread;
   logic                  thread_push;
   logic [THREAD_W-1:0]   thread_push_id;

   logic                  tag_empty;
   logic                  tag_avail;
   logic                  tag_pop;
   logic                  tag_push;
   logic [TAG_W-1:0]      tag_push_id;

   logic                  ctx_load;
   logic [CNT_W-1:0]      ctx_count;
   logic [THREAD_W-1:0]   req_thread;
   logic [ELEM_IDX_W-1:0] req_start;
   logic [REQ_CNT_W-1:0]  req_count;
   logic [THREAD_W-1:0]   out_thread;
   logic                  out_fire;

   assign thread_avail = !thread_empty;
   assign tag_avail    = !tag_empty;
   assign out_fire     = out_valid & out_ready;

   ar_burst_ctrl ar_burst_ctrl_inst (
      .clk           (clk),
      .rstn          (rstn),
      .task_in_valid (task_in_valid),
      .in_eo_begin   (in_eo_begin),
      .in_eo_end     (in_eo_end),
      .neighbor_base (neighbor_base),
      .arready       (arready),
      .thread_avail  (thread_avail),
      .tag_avail     (tag_avail),
      .alloc_thread  (alloc_thread),
      .task_in_ready (task_in_ready),
      .thread_pop    (thread_pop),
      .tag_pop       (tag_pop),
      .ctx_load      (ctx_load),
      .ctx_count     (ctx_count),
      .arvalid       (arvalid),
      .araddr        (araddr),
      .arlen         (arlen),
      .req_thread    (req_thread),
      .req_start     (req_start),
      .req_count     (req_count)
   );

   // read tags, arid is the head of the list
   tag_free_list #(.LOG_DEPTH(TAG_W)) tag_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (tag_push),
      .push_id (tag_push_id),
      .pop     (tag_pop),
      .pop_id  (arid),
      .empty   (tag_empty),
      .full    ()
   );

   tag_free_list #(.LOG_DEPTH(THREAD_W)) thread_list (
      .clk     (clk),
      .rstn    (rstn),
      .push    (thread_push),
      .push_id (thread_push_id),
      .pop     (thread_pop),
      .pop_id  (alloc_thread),
      .empty   (thread_empty),
      .full    (idle)               // every thread back home
   );

   line_unpacker line_unpacker_inst (
      .clk         (clk),
      .rstn        (rstn),
      .req_we      (tag_pop),
      .req_tag     (arid),
      .req_thread  (req_thread),
      .req_start   (req_start),
      .req_count   (req_count),
      .rvalid      (rvalid),
      .rid         (rid),
      .rdata       (rdata),
      .out_ready   (out_ready),
      .rready      (rready),
      .tag_push    (tag_push),
      .tag_push_id (tag_push_id),
      .out_valid   (out_valid),
      .out_data    (out_data),
      .out_thread  (out_thread)
   );

   thread_context thread_context_inst (
      .clk            (clk),
      .rstn           (rstn),
      .ctx_load       (ctx_load),
      .load_thread    (alloc_thread),
      .in_ts          (in_ts),
      .in_locale      (in_locale),
      .ctx_count      (ctx_count),
      .out_fire       (out_fire),
      .out_thread     (out_thread),
      .out_ts         (out_ts),
      .out_locale     (out_locale),
      .out_last       (out_last),
      .thread_push    (thread_push),
      .thread_push_id (thread_push_id)
   );

endmodule

//--- ro_stage_testdata.txt
// columns: test, ts, locale, eo_begin, eo_end, backpressure (all hex)
// rows with the same test number are driven back to back, zero test number ends the list
00000001 00000064 0000000b 00000002 00000007 00000000
00000002 000000c8 00000016 00000005 00000015 00000000
00000003 0000012c 00000021 00000009 00000009 00000000
00000004 00000190 0000002c 0000001e 00000032 00000001
00000005 000001f4 00000037 00000040 00000050 00000001
00000005 000001f5 00000038 00000051 0000005a 00000001
00000005 000001f6 00000039 00000003 00000005 00000001
00000005 000001f7 0000003a 000000c8 000000d5 00000001
00000005 000001f8 0000003b 00000011 00000012 00000001
00000005 000001f9 0000003c 00000028 0000003c 00000001

//--- tag_free_list.sv
`timescale 1ns/10ps

module tag_free_list #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_id,
   input  logic                 pop,
   output logic [LOG_DEPTH-1:0] pop_id,
   output logic                 empty,
   output logic                 full
);

   logic [LOG_DEPTH-1:0] ids [2**LOG_DEPTH];
   logic [LOG_DEPTH:0]   rd_ptr;   // extra bit tells full from empty
   logic [LOG_DEPTH:0]   wr_ptr;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < 2**LOG_DEPTH; i++) begin
            ids[i] <= LOG_DEPTH'(i);
         end
         rd_ptr <= '0;
         wr_ptr <= {1'b1, {LOG_DEPTH{1'b0}}};   // every id present
      end else begin
         if (push) begin
            ids[wr_ptr[LOG_DEPTH-1:0]] <= push_id;
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign pop_id = ids[rd_ptr[LOG_DEPTH-1:0]];
   assign empty  = (wr_ptr == rd_ptr);
   assign full   = (wr_ptr == {~rd_ptr[LOG_DEPTH], rd_ptr[LOG_DEPTH-1:0]});

   a_no_pop_empty : assert property (@(posedge clk) disable iff (!rstn)
      pop |-> !empty)
      else $error("free list popped while empty");

   a_no_push_full : assert property (@(posedge clk) disable iff (!rstn)
      push |-> !full)
      else $error("free list pushed while full");

endmodule

//--- tb_ro_stage.sv
`timescale 1ns/10ps

module tb_ro_stage import ro_pkg::*; ();

   localparam int MAX_ROWS  = 32;
   localparam int ROW_WORDS = 6;
   localparam logic [ADDR_W-1:0] BASE = 32'h0001_0000;

   logic                  clk = 1'b0;
   logic                  rstn;
   logic                  task_in_valid;
   logic                  task_in_ready;
   logic [TS_W-1:0]       in_ts;
   logic [VID_W-1:0]      in_locale;
   logic [EO_W-1:0]       in_eo_begin;
   logic [EO_W-1:0]       in_eo_end;
   logic [ADDR_W-1:0]     neighbor_base;
   logic                  arvalid;
   logic                  arready;
   logic [ADDR_W-1:0]     araddr;
   logic [ELEM_IDX_W-1:0] arlen;
   logic [TAG_W-1:0]      arid;
   logic                  rvalid;
   logic                  rready;
   logic [TAG_W-1:0]      rid;
   logic [LINE_W-1:0]     rdata;
   logic                  out_valid;
   logic                  out_ready;
   logic [TS_W-1:0]       out_ts;
   logic [VID_W-1:0]      out_locale;
   logic [DATA_W-1:0]     out_data;
   logic                  out_last;
   logic                  idle;

   logic [31:0] tdata [MAX_ROWS*ROW_WORDS];
   int          n_rows;
   int          errors = 0;
   int          cycles = 0;
   int          cycle_limit;
   int          inflight = 0;   // accepted tasks whose last edge has not left
   int          tests_run = 0;
   int          tests_passed = 0;
   logic        bp_mode = 1'b0;

   // expected output stream, in task accept order
   logic [TS_W-1:0]   exp_ts_q   [$];
   logic [VID_W-1:0]  exp_loc_q  [$];
   logic [DATA_W-1:0] exp_data_q [$];
   logic              exp_last_q [$];
   // ranges still to be requested, head is the task being split
   logic [EO_W-1:0]   ar_beg_q   [$];
   logic [EO_W-1:0]   ar_end_q   [$];
   // requests the memory model still has to answer
   logic [ADDR_W-1:0] mem_addr_q [$];
   logic [TAG_W-1:0]  mem_id_q   [$];

   always #50 clk = ~clk;

   ro_stage ro_stage_inst (
      .clk           (clk),
      .rstn          (rstn),
      .task_in_valid (task_in_valid),
      .task_in_ready (task_in_ready),
      .in_ts         (in_ts),
      .in_locale     (in_locale),
      .in_eo_begin   (in_eo_begin),
      .in_eo_end     (in_eo_end),
      .neighbor_base (neighbor_base),
      .arvalid       (arvalid),
      .arready       (arready),
      .araddr        (araddr),
      .arlen         (arlen),
      .arid          (arid),
      .rvalid        (rvalid),
      .rready        (rready),
      .rid           (rid),
      .rdata         (rdata),
      .out_valid     (out_valid),
      .out_ready     (out_ready),
      .out_ts        (out_ts),
      .out_locale    (out_locale),
      .out_data      (out_data),
      .out_last      (out_last),
      .idle          (idle)
   );

   function automatic logic [DATA_W-1:0] elem_data(input int e);
      return {32'(e * 7), 32'(e)};
   endfunction

   // whole 64-byte line around addr
   function automatic logic [LINE_W-1:0] line_data(input logic [ADDR_W-1:0] addr);
      logic [LINE_W-1:0] line;
      int                first;
      first = int'(((addr & ~ADDR_W'(ELEMS_PER_LINE * ELEM_BYTES - 1)) - BASE) >> 3);
      for (int j = 0; j < ELEMS_PER_LINE; j++) begin
         line[j*DATA_W +: DATA_W] = elem_data(first + j);
      end
      return line;
   endfunction

   task automatic report_error(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
   endtask

   task automatic check_ar(input logic [ADDR_W-1:0] got_addr,
                           input logic [ELEM_IDX_W-1:0] got_len,
                           input logic [ADDR_W-1:0] exp_addr,
                           input logic [ELEM_IDX_W-1:0] exp_len);
      if (got_addr !== exp_addr) begin
         $display("CHECK FAILED araddr got %h expected %h", got_addr, exp_addr);
         errors++;
      end
      if (got_len !== exp_len) begin
         $display("CHECK FAILED arlen got %h expected %h", got_len, exp_len);
         errors++;
      end
   endtask

   task automatic check_out(input logic [TS_W-1:0] got_ts, input logic [VID_W-1:0] got_loc,
                            input logic [DATA_W-1:0] got_data, input logic got_last,
                            input logic [TS_W-1:0] exp_ts, input logic [VID_W-1:0] exp_loc,
                            input logic [DATA_W-1:0] exp_data, input logic exp_last);
      if (got_ts !== exp_ts) begin
         $display("CHECK FAILED out_ts got %h expected %h", got_ts, exp_ts);
         errors++;
      end
      if (got_loc !== exp_loc) begin
         $display("CHECK FAILED out_locale got %h expected %h", got_loc, exp_loc);
         errors++;
      end
      if (got_data !== exp_data) begin
         $display("CHECK FAILED out_data got %h expected %h", got_data, exp_data);
         errors++;
      end
      if (got_last !== exp_last) begin
         $display("CHECK FAILED out_last got %h expected %h", got_last, exp_last);
         errors++;
      end
   endtask

   // memory model, scoreboard and ready generation
   always @(posedge clk) begin
      logic [EO_W-1:0]       beg;
      logic [EO_W-1:0]       stop;
      logic [ELEM_IDX_W-1:0] exp_len;
      logic [TS_W-1:0]       e_ts;
      logic [VID_W-1:0]      e_loc;
      logic [DATA_W-1:0]     e_data;
      logic                  e_last;
      if (rstn) begin
         // accept first, a thread freed on this edge was not free before it
         if (task_in_valid && task_in_ready && (in_eo_end != in_eo_begin)) begin
            if (inflight >= N_THREADS) begin
               report_error("task accepted while every thread was busy");
            end
            inflight++;
            ar_beg_q.push_back(in_eo_begin);
            ar_end_q.push_back(in_eo_end);
            for (int e = int'(in_eo_begin); e < int'(in_eo_end); e++) begin
               exp_ts_q.push_back(in_ts);
               exp_loc_q.push_back(in_locale);
               exp_data_q.push_back(elem_data(e));
               exp_last_q.push_back(e == int'(in_eo_end) - 1);
            end
         end
         if (arvalid && arready) begin
            if (ar_beg_q.size() == 0) begin
               report_error("read request issued with no task pending");
            end else begin
               beg  = ar_beg_q[0];
               stop = (beg & ~EO_W'(ELEMS_PER_LINE - 1)) + EO_W'(ELEMS_PER_LINE);
               if (stop > ar_end_q[0]) begin
                  stop = ar_end_q[0];
               end
               exp_len = ELEM_IDX_W'(stop - beg - 1);
               check_ar(araddr, arlen, BASE + (ADDR_W'(beg) << 3), exp_len);
               if (stop == ar_end_q[0]) begin
                  void'(ar_beg_q.pop_front());
                  void'(ar_end_q.pop_front());
               end else begin
                  ar_beg_q[0] = stop;
               end
            end
            mem_addr_q.push_back(araddr);
            mem_id_q.push_back(arid);
         end
         if (rvalid && rready) begin
            void'(mem_addr_q.pop_front());
            void'(mem_id_q.pop_front());
         end
         if (!(rvalid && !rready)) begin   // a pending beat holds
            if ((mem_addr_q.size() > 0) && (($urandom % 3) != 0)) begin
               rvalid <= 1'b1;
               rid    <= mem_id_q[0];
               rdata  <= line_data(mem_addr_q[0]);
            end else begin
               rvalid <= 1'b0;
            end
         end
         if (out_valid && out_ready) begin
            if (exp_data_q.size() == 0) begin
               report_error("output beat with no edge expected");
            end else begin
               e_ts   = exp_ts_q.pop_front();
               e_loc  = exp_loc_q.pop_front();
               e_data = exp_data_q.pop_front();
               e_last = exp_last_q.pop_front();
               check_out(out_ts, out_locale, out_data, out_last, e_ts, e_loc, e_data, e_last);
               if (e_last) begin
                  inflight--;
               end
            end
         end
         arready   <= (($urandom % 4) != 0);
         out_ready <= bp_mode ? (($urandom % 2) == 1) : 1'b1;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles > cycle_limit) begin
         $display("timeout: no finish within %0d cycles, the DUT stopped making progress",
                  cycle_limit);
         $display("test failed");
         $finish;
      end
   end

   task automatic run_test(input int first, input int last);
      int   err_before;
      int   waited;
      int   edges;
      logic empty;
      logic busy;
      err_before = errors;
      edges      = 0;
      busy       = 1'b0;
      bp_mode    = tdata[first*ROW_WORDS+5][0];
      @(posedge clk);
      for (int r = first; r <= last; r++) begin
         empty = (tdata[r*ROW_WORDS+3] == tdata[r*ROW_WORDS+4]);
         edges += int'(tdata[r*ROW_WORDS+4] - tdata[r*ROW_WORDS+3]);
         task_in_valid <= 1'b1;
         in_ts         <= tdata[r*ROW_WORDS+1];
         in_locale     <= tdata[r*ROW_WORDS+2];
         in_eo_begin   <= tdata[r*ROW_WORDS+3];
         in_eo_end     <= tdata[r*ROW_WORDS+4];
         waited = 0;
         do begin
            @(posedge clk);
            waited++;
         end while (!task_in_ready);
         if (empty && (waited != 1)) begin
            report_error("empty task was not consumed in one cycle");
         end
         busy = busy | !empty;
      end
      task_in_valid <= 1'b0;
      @(negedge clk);
      // only empty tasks so far, nothing may have started
      if (!busy && (!idle || arvalid)) begin
         report_error("an empty task took a thread or issued a read request");
      end
      // drained means every edge out and every thread home
      while ((exp_data_q.size() != 0) || (ar_beg_q.size() != 0) ||
             (mem_addr_q.size() != 0) || !idle) begin
         @(negedge clk);
      end
      tests_run++;
      if (errors == err_before) begin
         tests_passed++;
         $display("test %0d: %0d tasks, %0d edges, ok", tdata[first*ROW_WORDS],
                  last - first + 1, edges);
      end else begin
         $display("test %0d: %0d tasks, %0d edges, FAILED with %0d errors",
                  tdata[first*ROW_WORDS], last - first + 1, edges, errors - err_before);
      end
   endtask

   initial begin
      int r;
      int last;
      void'($urandom(32'h34ed6575));
      task_in_valid <= 1'b0;
      in_ts         <= '0;
      in_locale     <= '0;
      in_eo_begin   <= '0;
      in_eo_end     <= '0;
      neighbor_base <= BASE;
      arready       <= 1'b0;
      rvalid        <= 1'b0;
      rid           <= '0;
      rdata         <= '0;
      out_ready     <= 1'b0;
      rstn          <= 1'b0;
      for (int i = 0; i < MAX_ROWS * ROW_WORDS; i++) begin
         tdata[i] = '0;
      end
      $readmemh("ro_stage_testdata.txt", tdata);
      n_rows      = 0;
      cycle_limit = 30;   // reset and settling
      while ((n_rows < MAX_ROWS) && (tdata[n_rows*ROW_WORDS] != 0)) begin
         cycle_limit += 50 * int'(tdata[n_rows*ROW_WORDS+4] - tdata[n_rows*ROW_WORDS+3]) + 40;
         n_rows++;
      end
      repeat (10) @(posedge clk);
      rstn <= 1'b1;
      @(posedge clk);
      @(negedge clk);
      if (!idle || arvalid || out_valid || task_in_ready) begin
         report_error("outputs not at rest one cycle after reset");
      end
      if (n_rows == 0) begin
         report_error("no tasks found in ro_stage_testdata.txt");
      end
      r = 0;
      while (r < n_rows) begin
         last = r;
         while ((last + 1 < n_rows) &&
                (tdata[(last+1)*ROW_WORDS] == tdata[r*ROW_WORDS])) begin
            last++;
         end
         run_test(r, last);
         r = last + 1;
      end
      $display("tests run %0d, passed %0d, failed %0d, errors %0d",
               tests_run, tests_passed, tests_run - tests_passed, errors);
      if (errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

//--- thread_context.sv
`timescale 1ns/10ps

module thread_context import ro_pkg::*; (
   input  logic                clk,
   input  logic                rstn,
   input  logic                ctx_load,
   input  logic [THREAD_W-1:0] load_thread,
   input  logic [TS_W-1:0]     in_ts,
   input  logic [VID_W-1:0]    in_locale,
   input  logic [CNT_W-1:0]    ctx_count,
   input  logic                out_fire,
   input  logic [THREAD_W-1:0] out_thread,
   output logic [TS_W-1:0]     out_ts,
   output logic [VID_W-1:0]    out_locale,
   output logic                out_last,
   output logic                thread_push,
   output logic [THREAD_W-1:0] thread_push_id
);

   logic [TS_W-1:0]  ctx_ts     [N_THREADS];
   logic [VID_W-1:0] ctx_locale [N_THREADS];
   logic [CNT_W-1:0] remaining  [N_THREADS];   // edges not yet emitted

   always_ff @(posedge clk) begin
      if (ctx_load) begin
         ctx_ts[load_thread]     <= in_ts;
         ctx_locale[load_thread] <= in_locale;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int t = 0; t < N_THREADS; t++) begin
            remaining[t] <= '0;
         end
      end else begin
         for (int t = 0; t < N_THREADS; t++) begin
            if (ctx_load && (load_thread == THREAD_W'(t))) begin
               remaining[t] <= ctx_count;
            end else if (out_fire && (out_thread == THREAD_W'(t))) begin
               remaining[t] <= remaining[t] - 1'b1;
            end
         end
      end
   end

   assign out_ts     = ctx_ts[out_thread];
   assign out_locale = ctx_locale[out_thread];
   assign out_last   = (remaining[out_thread] == CNT_W'(1));

   // thread goes back to the free list with its final edge
   assign thread_push    = out_fire & out_last;
   assign thread_push_id = out_thread;

endmodule
